/* source/apb_sub_pkg.sv */
/* Shared address map and APB types. Every register is a 32-bit word
   and paddr carries only the low 12 bits of a 64 KB window */
package apb_sub_pkg;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------
  localparam logic [31:0] APB_BASE    = 32'h0080_0000; // Window 0 start
  localparam int          WIN_BITS    = 16;            // 64 KB per window
  localparam int          NUM_SLAVES  = 3;
  localparam int          NUM_TIMERS  = 3;
  localparam int          NUM_EXT_IRQ = 4;             // MAC and DMA stand-ins

  localparam logic [1:0] HRESP_OKAY  = 2'b00;
  localparam logic [1:0] HRESP_ERROR = 2'b01;

  typedef enum logic [1:0] {
    SLV_GPIO  = 2'd0,
    SLV_TIMER = 2'd1,
    SLV_WAKE  = 2'd2
  } slave_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_ERR1,   // ERROR with hready low
    ST_ERR2    // ERROR with hready high
  } bridge_state_e;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // Broadcast to all slaves
  typedef struct packed {
    logic [11:0] paddr;   // Offset inside the window
    logic        pwrite;
    logic [31:0] pwdata;
    logic        penable;
  } apb_req_t;

  // One per slave
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
  } apb_rsp_t;

  // --------------------------------------------------
  // Register offsets
  // --------------------------------------------------
  localparam logic [11:0] GPIO_DOUT  = 12'h000;
  localparam logic [11:0] GPIO_OE    = 12'h004;
  localparam logic [11:0] GPIO_DIN   = 12'h008;
  localparam logic [11:0] GPIO_IEN   = 12'h00C;
  localparam logic [11:0] GPIO_ISTAT = 12'h010;

  // Timer n sits at 0x10*n plus these
  localparam logic [3:0] TMR_LOAD  = 4'h0;
  localparam logic [3:0] TMR_CTRL  = 4'h4;
  localparam logic [3:0] TMR_VALUE = 4'h8;
  localparam logic [3:0] TMR_STAT  = 4'hC;

  localparam logic [11:0] WAKE_ISO  = 12'h000;
  localparam logic [11:0] WAKE_MASK = 12'h004;
  localparam logic [11:0] WAKE_STAT = 12'h008;

endpackage

/* source/ahb_apb_bridge.sv */
`timescale 1ns/100ps
/* Single word transfers only. Bursts, hsize and protection are not supported
   An address outside the three windows gets a two-cycle ERROR response */
module ahb_apb_bridge (
  input  logic                               i_hclk,
  input  logic                               i_rst_n,
  // AHB-Lite slave side
  input  logic                               i_hsel,
  input  logic [31:0]                        i_haddr,
  input  apb_sub_pkg::htrans_e               i_htrans,
  input  logic                               i_hwrite,
  input  logic [31:0]                        i_hwdata,
  input  logic                               i_hready_in,
  output logic [31:0]                        o_hrdata,
  output logic                               o_hready,
  output logic [1:0]                         o_hresp,
  // APB master side
  output apb_sub_pkg::apb_req_t              o_apb_req,
  output logic [apb_sub_pkg::NUM_SLAVES-1:0] o_psel,
  input  apb_sub_pkg::apb_rsp_t              i_apb_rsp [apb_sub_pkg::NUM_SLAVES]
);
  import apb_sub_pkg::*;

  localparam logic [31-WIN_BITS:0] LAST_WIN = (32 - WIN_BITS)'(NUM_SLAVES - 1);

  bridge_state_e        state_q;
  bridge_state_e        state_d;
  logic [31-WIN_BITS:0] win_idx;   // Window number relative to APB_BASE
  logic                 win_hit;
  logic                 accept;
  logic [11:0]          paddr_q;
  logic                 pwrite_q;
  slave_e               sel_q;
  logic [31:0]          rdata_q;
  apb_rsp_t             sel_rsp;

  // --------------------------------------------------
  // Address phase decode
  // --------------------------------------------------
  assign win_idx = i_haddr[31:WIN_BITS] - APB_BASE[31:WIN_BITS];
  assign win_hit = (win_idx <= LAST_WIN); // Wraps below APB_BASE so one compare
  assign accept  = i_hsel && i_hready_in && o_hready && (i_htrans inside {NONSEQ, SEQ});
  assign sel_rsp = i_apb_rsp[sel_q];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE, ST_ERR2: begin     // Both present hready high
        if (accept) begin
          state_d = win_hit ? ST_SETUP : ST_ERR1;
        end else begin
          state_d = ST_IDLE;
        end
      end
      ST_SETUP: state_d = ST_ACCESS;
      ST_ACCESS: begin
        if (sel_rsp.pready) begin   // Low pready holds ACCESS
          state_d = ST_IDLE;
        end
      end
      ST_ERR1: state_d = ST_ERR2;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address and read data holding
  always_ff @(posedge i_hclk) begin
    if (accept) begin
      paddr_q  <= i_haddr[11:0];
      pwrite_q <= i_hwrite;
      sel_q    <= slave_e'(win_idx[$bits(slave_e)-1:0]);
    end
    if (state_q == ST_ACCESS && sel_rsp.pready) begin
      rdata_q <= sel_rsp.prdata;  // Shown in the cycle hready rises
    end
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  assign o_hready = (state_q == ST_IDLE) || (state_q == ST_ERR2);
  assign o_hresp  = (state_q inside {ST_ERR1, ST_ERR2}) ? HRESP_ERROR : HRESP_OKAY;
  assign o_hrdata = rdata_q;
  assign o_psel   = (state_q inside {ST_SETUP, ST_ACCESS}) ? (NUM_SLAVES'(1) << sel_q) : '0;

  // hwdata is held by the master while hready is low
  assign o_apb_req = '{
    paddr:   paddr_q,
    pwrite:  pwrite_q,
    pwdata:  i_hwdata,
    penable: (state_q == ST_ACCESS)
  };

  // One slave in SETUP and ACCESS and none otherwise
  a_psel_onehot: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
    $onehot0(o_psel) && ((state_q inside {ST_SETUP, ST_ACCESS}) == (|o_psel)));

  // ACCESS only follows a SETUP to the same slave
  a_penable_setup: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
    o_apb_req.penable |-> (|o_psel) && $stable(o_psel));

endmodule

/* source/apb_gpio.sv */
`timescale 1ns/100ps
/* GPIO_WIDTH up to 32. Inputs are asynchronous and reach the status
   register three clocks after a pin edge */
module apb_gpio #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                  i_hclk,
  input  logic                  i_rst_n,
  input  logic                  i_psel,
  input  apb_sub_pkg::apb_req_t i_apb_req,
  output apb_sub_pkg::apb_rsp_t o_apb_rsp,
  input  logic [GPIO_WIDTH-1:0] i_gpio_pin_in,
  output logic [GPIO_WIDTH-1:0] o_gpio_pin_out,
  output logic [GPIO_WIDTH-1:0] o_n_gpio_pin_oe,
  output logic                  o_gpio_irq
);
  import apb_sub_pkg::*;

  logic [GPIO_WIDTH-1:0] dout_q;
  logic [GPIO_WIDTH-1:0] oe_q;
  logic [GPIO_WIDTH-1:0] ien_q;
  logic [GPIO_WIDTH-1:0] istat_q;
  logic [GPIO_WIDTH-1:0] sync1_q;   // Metastability stage
  logic [GPIO_WIDTH-1:0] sync2_q;
  logic [GPIO_WIDTH-1:0] prev_q;    // For edge detect
  logic [GPIO_WIDTH-1:0] rise;
  logic [GPIO_WIDTH-1:0] istat_clr;
  logic [GPIO_WIDTH-1:0] wr_data;
  logic                  wr_en;

  assign wr_en     = i_psel && i_apb_req.penable && i_apb_req.pwrite;
  assign wr_data   = i_apb_req.pwdata[GPIO_WIDTH-1:0];
  assign rise      = sync2_q & ~prev_q;
  assign istat_clr = (wr_en && i_apb_req.paddr == GPIO_ISTAT) ? wr_data : '0;

  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      dout_q  <= '0;
      oe_q    <= '0;   // All pins start as inputs
      ien_q   <= '0;
      istat_q <= '0;
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= i_gpio_pin_in;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr_en) begin
        case (i_apb_req.paddr)
          GPIO_DOUT: dout_q <= wr_data;
          GPIO_OE:   oe_q   <= wr_data;
          GPIO_IEN:  ien_q  <= wr_data;
          default:   ;
        endcase
      end
      // New edge wins over a clear in the same cycle
      istat_q <= (istat_q & ~istat_clr) | rise;
    end
  end

  // --------------------------------------------------
  // Read mux and pins
  // --------------------------------------------------
  always_comb begin
    o_apb_rsp.pready = 1'b1;   // Zero wait states
    o_apb_rsp.prdata = '0;
    case (i_apb_req.paddr)
      GPIO_DOUT:  o_apb_rsp.prdata[GPIO_WIDTH-1:0] = dout_q;
      GPIO_OE:    o_apb_rsp.prdata[GPIO_WIDTH-1:0] = oe_q;
      GPIO_DIN:   o_apb_rsp.prdata[GPIO_WIDTH-1:0] = sync2_q;
      GPIO_IEN:   o_apb_rsp.prdata[GPIO_WIDTH-1:0] = ien_q;
      GPIO_ISTAT: o_apb_rsp.prdata[GPIO_WIDTH-1:0] = istat_q;
      default:    ;
    endcase
  end

  assign o_gpio_pin_out  = dout_q;
  assign o_n_gpio_pin_oe = ~oe_q;   // Pad enable is active low
  assign o_gpio_irq      = |(istat_q & ien_q);

endmodule

/* source/apb_timer.sv */
`timescale 1ns/100ps
/* Three 32-bit down counters clocked by hclk without a prescaler
   Auto-reload period is load plus one clocks */
module apb_timer (
  input  logic                               i_hclk,
  input  logic                               i_rst_n,
  input  logic                               i_psel,
  input  apb_sub_pkg::apb_req_t              i_apb_req,
  output apb_sub_pkg::apb_rsp_t              o_apb_rsp,
  output logic [apb_sub_pkg::NUM_TIMERS-1:0] o_ttc_irq
);
  import apb_sub_pkg::*;

  logic [31:0]           load_q [NUM_TIMERS];
  logic [31:0]           cnt_q  [NUM_TIMERS];
  logic [NUM_TIMERS-1:0] en_q;
  logic [NUM_TIMERS-1:0] arl_q;   // Auto-reload select
  logic [NUM_TIMERS-1:0] stat_q;  // Sticky expiry
  logic                  wr_en;
  logic [1:0]            tmr_sel;
  logic [3:0]            reg_sel;
  logic [31:0]           wdata;

  assign wr_en   = i_psel && i_apb_req.penable && i_apb_req.pwrite;
  assign tmr_sel = i_apb_req.paddr[5:4];   // 0x10 stride per timer
  assign reg_sel = i_apb_req.paddr[3:0];
  assign wdata   = i_apb_req.pwdata;

  // --------------------------------------------------
  // One counter per timer
  // --------------------------------------------------
  for (genvar t = 0; t < NUM_TIMERS; t++) begin : g_tmr
    logic hit;
    logic ld_wr;
    logic ctrl_wr;
    logic stat_clr;

    assign hit      = wr_en && (tmr_sel == t);
    assign ld_wr    = hit && (reg_sel == TMR_LOAD);
    assign ctrl_wr  = hit && (reg_sel == TMR_CTRL);
    assign stat_clr = hit && (reg_sel == TMR_STAT) && wdata[0];

    always_ff @(posedge i_hclk) begin
      if (ld_wr) begin
        load_q[t] <= wdata;
      end
    end

    always_ff @(posedge i_hclk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        cnt_q[t]  <= '0;
        en_q[t]   <= 1'b0;
        arl_q[t]  <= 1'b0;
        stat_q[t] <= 1'b0;
      end else begin
        if (stat_clr) begin
          stat_q[t] <= 1'b0;
        end
        if (ctrl_wr) begin
          en_q[t]  <= wdata[0];
          arl_q[t] <= wdata[1];
          if (wdata[0]) begin
            cnt_q[t] <= load_q[t];   // Start from the load value
          end
        end else if (en_q[t]) begin
          if (cnt_q[t] == 32'd1) begin
            cnt_q[t]  <= '0;
            stat_q[t] <= 1'b1;       // Expiry at the edge reaching zero
            en_q[t]   <= arl_q[t];   // One-shot stops here
          end else if (cnt_q[t] == '0) begin
            cnt_q[t] <= load_q[t];
          end else begin
            cnt_q[t] <= cnt_q[t] - 32'd1;
          end
        end
      end
    end

    assign o_ttc_irq[t] = stat_q[t];

    // A stopped counter moves only by a start from the load value
    a_hold_when_off: assert property (@(posedge i_hclk) disable iff (!i_rst_n)
      !en_q[t] |=> $stable(cnt_q[t]) || (en_q[t] && cnt_q[t] == load_q[t]));
  end

  always_comb begin
    o_apb_rsp.pready = 1'b1;
    o_apb_rsp.prdata = '0;
    if (tmr_sel < NUM_TIMERS) begin   // Slot 3 reads zero
      case (reg_sel)
        TMR_LOAD:  o_apb_rsp.prdata = load_q[tmr_sel];
        TMR_CTRL:  o_apb_rsp.prdata = {30'd0, arl_q[tmr_sel], en_q[tmr_sel]};
        TMR_VALUE: o_apb_rsp.prdata = cnt_q[tmr_sel];
        TMR_STAT:  o_apb_rsp.prdata = {31'd0, stat_q[tmr_sel]};
        default:   ;
      endcase
    end
  end

endmodule

/* source/apb_wake_ctrl.sv */
`timescale 1ns/100ps
/* Sources are level sensitive. In hibernate only the GPIO interrupt wakes
   and the mask is bypassed */
module apb_wake_ctrl (
  input  logic                                i_hclk,
  input  logic                                i_rst_n,
  input  logic                                i_psel,
  input  apb_sub_pkg::apb_req_t               i_apb_req,
  output apb_sub_pkg::apb_rsp_t               o_apb_rsp,
  input  logic                                i_gpio_irq,
  input  logic [apb_sub_pkg::NUM_TIMERS-1:0]  i_ttc_irq,
  input  logic [apb_sub_pkg::NUM_EXT_IRQ-1:0] i_ext_irq,
  output logic                                o_pcm_irq,
  output logic                                o_isolate_mem
);
  import apb_sub_pkg::*;

  localparam int NUM_SRC = 1 + NUM_TIMERS + NUM_EXT_IRQ;

  logic               iso_q;    // Hibernate
  logic               stat_q;   // Sticky wake
  logic [NUM_SRC-1:0] mask_q;   // 1 blocks a source
  logic [NUM_SRC-1:0] src;
  logic               wr_en;
  logic               wake;

  assign wr_en = i_psel && i_apb_req.penable && i_apb_req.pwrite;
  assign src   = {i_ext_irq, i_ttc_irq, i_gpio_irq};   // GPIO at bit 0

  // Sleep wakes on any unmasked source and hibernate only on GPIO
  assign wake = iso_q ? i_gpio_irq : |(src & ~mask_q);

  always_ff @(posedge i_hclk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      iso_q  <= 1'b0;
      stat_q <= 1'b0;
      mask_q <= '0;
    end else begin
      if (wr_en && i_apb_req.paddr == WAKE_ISO) begin
        iso_q <= i_apb_req.pwdata[0];
      end
      if (iso_q && i_gpio_irq) begin
        iso_q <= 1'b0;   // Leave hibernate
      end
      if (wr_en && i_apb_req.paddr == WAKE_MASK) begin
        mask_q <= i_apb_req.pwdata[NUM_SRC-1:0];
      end
      if (wr_en && i_apb_req.paddr == WAKE_STAT && i_apb_req.pwdata[0]) begin
        stat_q <= 1'b0;
      end
      if (wake) begin
        stat_q <= 1'b1;  // Set beats clear
      end
    end
  end

  always_comb begin
    o_apb_rsp.pready = 1'b1;
    o_apb_rsp.prdata = '0;
    case (i_apb_req.paddr)
      WAKE_ISO:  o_apb_rsp.prdata[0]         = iso_q;
      WAKE_MASK: o_apb_rsp.prdata[NUM_SRC-1:0] = mask_q;
      WAKE_STAT: o_apb_rsp.prdata[0]         = stat_q;
      default:   ;
    endcase
  end

  assign o_pcm_irq     = stat_q;
  assign o_isolate_mem = iso_q;

endmodule

/* source/apb_subsystem.sv */
`timescale 1ns/100ps
/* One clock domain with APB running on hclk
   Windows of 64 KB from 0x0080_0000 hold GPIO then timers then wake control */
module apb_subsystem #(
  parameter int GPIO_WIDTH = 16
) (
  input  logic                                i_hclk,
  input  logic                                i_rst_n,
  // AHB-Lite slave port
  input  logic                                i_hsel,
  input  logic [31:0]                         i_haddr,
  input  apb_sub_pkg::htrans_e                i_htrans,
  input  logic                                i_hwrite,
  input  logic [31:0]                         i_hwdata,
  input  logic                                i_hready_in,
  output logic [31:0]                         o_hrdata,
  output logic                                o_hready,
  output logic [1:0]                          o_hresp,
  // GPIO pads
  input  logic [GPIO_WIDTH-1:0]               i_gpio_pin_in,
  output logic [GPIO_WIDTH-1:0]               o_gpio_pin_out,
  output logic [GPIO_WIDTH-1:0]               o_n_gpio_pin_oe,
  // Interrupts
  input  logic [apb_sub_pkg::NUM_EXT_IRQ-1:0] i_ext_irq,
  output logic                                o_gpio_irq,
  output logic [apb_sub_pkg::NUM_TIMERS-1:0]  o_ttc_irq,
  output logic                                o_pcm_irq,
  // Power
  output logic                                o_isolate_mem
);
  import apb_sub_pkg::*;

  apb_req_t              apb_req;               // Shared by all slaves
  apb_rsp_t              apb_rsp [NUM_SLAVES];  // Indexed by slave_e
  logic [NUM_SLAVES-1:0] psel;

  ahb_apb_bridge u_bridge (
    .i_hclk      (i_hclk),
    .i_rst_n     (i_rst_n),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hwdata    (i_hwdata),
    .i_hready_in (i_hready_in),
    .o_hrdata    (o_hrdata),
    .o_hready    (o_hready),
    .o_hresp     (o_hresp),
    .o_apb_req   (apb_req),
    .o_psel      (psel),
    .i_apb_rsp   (apb_rsp)
  );

  apb_gpio #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) u_gpio (
    .i_hclk          (i_hclk),
    .i_rst_n         (i_rst_n),
    .i_psel          (psel[SLV_GPIO]),
    .i_apb_req       (apb_req),
    .o_apb_rsp       (apb_rsp[SLV_GPIO]),
    .i_gpio_pin_in   (i_gpio_pin_in),
    .o_gpio_pin_out  (o_gpio_pin_out),
    .o_n_gpio_pin_oe (o_n_gpio_pin_oe),
    .o_gpio_irq      (o_gpio_irq)
  );

  apb_timer u_timer (
    .i_hclk    (i_hclk),
    .i_rst_n   (i_rst_n),
    .i_psel    (psel[SLV_TIMER]),
    .i_apb_req (apb_req),
    .o_apb_rsp (apb_rsp[SLV_TIMER]),
    .o_ttc_irq (o_ttc_irq)
  );

  // Sees the same interrupt lines that leave the top
  apb_wake_ctrl u_wake (
    .i_hclk        (i_hclk),
    .i_rst_n       (i_rst_n),
    .i_psel        (psel[SLV_WAKE]),
    .i_apb_req     (apb_req),
    .o_apb_rsp     (apb_rsp[SLV_WAKE]),
    .i_gpio_irq    (o_gpio_irq),
    .i_ttc_irq     (o_ttc_irq),
    .i_ext_irq     (i_ext_irq),
    .o_pcm_irq     (o_pcm_irq),
    .o_isolate_mem (o_isolate_mem)
  );

endmodule

/* dv/tb_ahb_tasks.svh */
/* AHB-Lite master tasks, included in the testbench top. Each task starts and
   ends on a falling edge and runs one transfer at a time */
`ifndef TB_AHB_TASKS_SVH
`define TB_AHB_TASKS_SVH

// Address phase, driven at once. The caller is already on a falling edge
task automatic start_transfer(input logic [31:0] addr, input logic write);
  assert (hready === 1'b1) else report_mismatch("Transfer started while hready low");
  hsel   = 1'b1;
  haddr  = addr;
  htrans = NONSEQ;
  hwrite = write;
  @(negedge hclk);   // Accepting edge has passed
  hsel   = 1'b0;
  htrans = IDLE;
endtask

// Data phase of a mapped access, which is two stall cycles then OKAY
task automatic finish_transfer(input logic [31:0] addr);
  int low_cycles;
  low_cycles = 0;
  while (hready !== 1'b1 && low_cycles < DATA_PHASE_LIMIT) begin
    low_cycles++;
    @(negedge hclk);
  end
  assert (low_cycles == 2)
    else report_mismatch($sformatf("hready low %0d cycles at %h", low_cycles, addr));
  assert (hresp === HRESP_OKAY)
    else report_mismatch($sformatf("hresp %b at %h, expected OKAY", hresp, addr));
endtask

task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data);
  start_transfer(addr, 1'b1);
  hwdata = data;   // Held through the data phase
  finish_transfer(addr);
endtask

task automatic ahb_read(input logic [31:0] addr, output logic [31:0] data);
  start_transfer(addr, 1'b0);
  finish_transfer(addr);
  data = hrdata;   // Valid in the cycle hready is high
endtask

`endif

/* dv/tb_apb_subsystem.sv */
`timescale 1ns/100ps
/* Checks the subsystem through its AHB-Lite port with GPIO_WIDTH 16
   Wake mask bits follow the source order gpio, timers 0..2, ext 0..3 */
module tb_apb_subsystem;
  import apb_sub_pkg::*;

  localparam int          GPIO_WIDTH       = 16;
  localparam int          CLK_PERIOD       = 10;
  localparam int          DATA_PHASE_LIMIT = 16;   // Stall cycles before giving up
  localparam int          MAX_XFERS        = 200;
  localparam int          XFER_CYCLES      = 20;   // Transfer plus idle gaps
  localparam int          MAX_LOAD         = 64;   // Longest timer load used
  localparam int          WATCHDOG_NS      = (MAX_XFERS * XFER_CYCLES + MAX_LOAD) * CLK_PERIOD;
  localparam logic [31:0] GPIO_MASK        = (32'd1 << GPIO_WIDTH) - 32'd1;

  logic                   hclk;
  logic                   rst_n;
  logic                   hsel;
  logic [31:0]            haddr;
  htrans_e                htrans;
  logic                   hwrite;
  logic [31:0]            hwdata;
  logic                   hready_in;
  logic [31:0]            hrdata;
  logic                   hready;
  logic [1:0]             hresp;
  logic [GPIO_WIDTH-1:0]  gpio_in;
  logic [GPIO_WIDTH-1:0]  gpio_out;
  logic [GPIO_WIDTH-1:0]  n_gpio_oe;
  logic [NUM_EXT_IRQ-1:0] ext_irq;
  logic                   gpio_irq;
  logic [NUM_TIMERS-1:0]  ttc_irq;
  logic                   pcm_irq;
  logic                   isolate_mem;

  apb_subsystem #(
    .GPIO_WIDTH (GPIO_WIDTH)
  ) u_dut (
    .i_hclk          (hclk),
    .i_rst_n         (rst_n),
    .i_hsel          (hsel),
    .i_haddr         (haddr),
    .i_htrans        (htrans),
    .i_hwrite        (hwrite),
    .i_hwdata        (hwdata),
    .i_hready_in     (hready_in),
    .o_hrdata        (hrdata),
    .o_hready        (hready),
    .o_hresp         (hresp),
    .i_gpio_pin_in   (gpio_in),
    .o_gpio_pin_out  (gpio_out),
    .o_n_gpio_pin_oe (n_gpio_oe),
    .i_ext_irq       (ext_irq),
    .o_gpio_irq      (gpio_irq),
    .o_ttc_irq       (ttc_irq),
    .o_pcm_irq       (pcm_irq),
    .o_isolate_mem   (isolate_mem)
  );

  // --------------------------------------------------
  // Failure reporting and helpers
  // --------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("ERROR at %0t ns: %s", $time, msg));
  endtask

  `include "tb_ahb_tasks.svh"

  function automatic logic [31:0] reg_addr(input slave_e slv, input logic [11:0] off);
    return APB_BASE + (32'(slv) << WIN_BITS) + {20'd0, off};
  endfunction

  function automatic logic [11:0] tmr_reg(input int n, input logic [3:0] r);
    return 12'(n * 16) + {8'd0, r};   // 0x10 stride
  endfunction

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] got;
    ahb_read(addr, got);
    assert (got === exp)
      else report_mismatch($sformatf("%s read %h, expected %h", what, got, exp));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge hclk);
  endtask

  task automatic wait_ttc(input int idx, input int limit);
    int n;
    n = 0;
    while (ttc_irq[idx] !== 1'b1 && n < limit) begin
      @(negedge hclk);
      n++;
    end
    assert (ttc_irq[idx] === 1'b1)
      else report_mismatch($sformatf("Timer %0d irq missing after %0d cycles", idx, limit));
  endtask

  task automatic wait_gpio_irq(input int limit);
    int n;
    n = 0;
    while (gpio_irq !== 1'b1 && n < limit) begin
      @(negedge hclk);
      n++;
    end
    assert (gpio_irq === 1'b1) else report_mismatch("GPIO irq missing after pin edge");
  endtask

  // One-shot run to expiry
  task automatic run_one_shot(input int idx, input int load);
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(idx, TMR_LOAD)), 32'(load));
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(idx, TMR_CTRL)), 32'h1);
    wait_ttc(idx, load + 8);
  endtask

  // Unmapped access: ERROR with hready low, then ERROR with hready high
  task automatic error_read(input logic [31:0] addr);
    start_transfer(addr, 1'b0);
    assert (hresp === HRESP_ERROR && hready === 1'b0 && u_dut.psel == '0)
      else report_mismatch($sformatf("First error cycle wrong at %h", addr));
    @(negedge hclk);
    assert (hresp === HRESP_ERROR && hready === 1'b1 && u_dut.psel == '0)
      else report_mismatch($sformatf("Second error cycle wrong at %h", addr));
  endtask

  // --------------------------------------------------
  // Clock and watchdog
  // --------------------------------------------------
  initial begin
    hclk = 1'b0;
    forever #(CLK_PERIOD / 2) hclk = ~hclk;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("Watchdog expired before the test sequence finished");
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    logic [31:0] dout;
    logic [31:0] oe;
    logic [31:0] bit_mask;
    int          pin;
    int          load;
    int          cycles;
    time         t0;

    void'($urandom(32'h5ce0_ba9c));
    rst_n     = 1'b0;
    hsel      = 1'b0;
    haddr     = '0;
    htrans    = IDLE;
    hwrite    = 1'b0;
    hwdata    = '0;
    hready_in = 1'b1;
    gpio_in   = '0;
    ext_irq   = '0;
    repeat (3) @(posedge hclk);
    @(negedge hclk);
    rst_n = 1'b1;

    // 1. Reset state
    assert (hready === 1'b1 && hresp === HRESP_OKAY) else report_mismatch("Bus not idle");
    assert (gpio_irq === 1'b0 && ttc_irq === '0 && pcm_irq === 1'b0)
      else report_mismatch("Interrupt high after reset");
    assert (n_gpio_oe === '1) else report_mismatch("Output enable on after reset");
    assert (isolate_mem === 1'b0) else report_mismatch("Isolate high after reset");
    assert (u_dut.psel == '0 && u_dut.apb_req.penable == 1'b0)
      else report_mismatch("APB select active after reset");

    // 2. GPIO data and enables
    repeat (8) begin
      dout = $urandom;
      oe   = $urandom;
      ahb_write(reg_addr(SLV_GPIO, GPIO_DOUT), dout);
      ahb_write(reg_addr(SLV_GPIO, GPIO_OE), oe);
      read_check(reg_addr(SLV_GPIO, GPIO_DOUT), dout & GPIO_MASK, "GPIO_DOUT");
      read_check(reg_addr(SLV_GPIO, GPIO_OE), oe & GPIO_MASK, "GPIO_OE");
      assert (gpio_out === dout[GPIO_WIDTH-1:0]) else report_mismatch("Pin out mismatch");
      assert (n_gpio_oe === ~oe[GPIO_WIDTH-1:0]) else report_mismatch("Pin enable mismatch");
    end

    // 3. GPIO rising edge interrupt
    pin      = int'($urandom % GPIO_WIDTH);
    bit_mask = 32'd1 << pin;
    ahb_write(reg_addr(SLV_GPIO, GPIO_IEN), bit_mask);
    gpio_in[pin] = 1'b1;
    wait_gpio_irq(8);
    read_check(reg_addr(SLV_GPIO, GPIO_ISTAT), bit_mask, "GPIO_ISTAT");
    read_check(reg_addr(SLV_GPIO, GPIO_DIN), bit_mask, "GPIO_DIN");
    ahb_write(reg_addr(SLV_GPIO, GPIO_ISTAT), bit_mask);   // Write 1 clears
    assert (gpio_irq === 1'b0) else report_mismatch("GPIO irq stays after clear");
    gpio_in[pin] = 1'b0;
    idle_cycles(6);
    assert (gpio_irq === 1'b0) else report_mismatch("Falling edge raised GPIO irq");
    read_check(reg_addr(SLV_GPIO, GPIO_ISTAT), 32'd0, "GPIO_ISTAT after fall");

    // 4. One-shot on timer 1
    load = 8 + int'($urandom % 24);
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(1, TMR_LOAD)), 32'(load));
    t0 = $time;
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(1, TMR_CTRL)), 32'h1);
    wait_ttc(1, load + 8);
    cycles = int'(($time - t0) / CLK_PERIOD);
    assert (cycles >= load && cycles <= load + 3)
      else report_mismatch($sformatf("Timer expired after %0d cycles, load %0d", cycles, load));
    read_check(reg_addr(SLV_TIMER, tmr_reg(1, TMR_VALUE)), 32'd0, "TMR_VALUE");
    read_check(reg_addr(SLV_TIMER, tmr_reg(1, TMR_CTRL)), 32'd0, "TMR_CTRL one-shot");
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(1, TMR_STAT)), 32'h1);
    assert (ttc_irq[1] === 1'b0) else report_mismatch("Timer irq stays after clear");

    // Auto-reload on timer 2
    load = 6 + int'($urandom % 10);
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(2, TMR_LOAD)), 32'(load));
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(2, TMR_CTRL)), 32'h3);
    wait_ttc(2, load + 8);
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(2, TMR_STAT)), 32'h1);
    assert (ttc_irq[2] === 1'b0) else report_mismatch("Reload irq stays after clear");
    wait_ttc(2, load + 8);   // Sets again without a new CTRL write
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(2, TMR_CTRL)), 32'h0);
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(2, TMR_STAT)), 32'h1);
    idle_cycles(load + 4);   // Longer than one reload period
    assert (ttc_irq[2] === 1'b0) else report_mismatch("Stopped timer irq still high");

    // 5. Unmapped windows
    error_read(32'h0090_0000);
    error_read(32'h007F_0000);   // Just below the map

    // 6. Wake control, sources quiet first
    ahb_write(reg_addr(SLV_WAKE, WAKE_MASK), 32'h0000_00FF);
    ahb_write(reg_addr(SLV_WAKE, WAKE_STAT), 32'h1);
    assert (pcm_irq === 1'b0) else report_mismatch("Wake status not cleared");
    ahb_write(reg_addr(SLV_WAKE, WAKE_MASK), 32'h0000_00FD);   // Timer 0 open
    run_one_shot(0, 5);
    idle_cycles(2);
    assert (pcm_irq === 1'b1) else report_mismatch("Unmasked timer caused no wake");
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(0, TMR_STAT)), 32'h1);
    ahb_write(reg_addr(SLV_WAKE, WAKE_STAT), 32'h1);
    assert (pcm_irq === 1'b0) else report_mismatch("Wake status stays after clear");
    ahb_write(reg_addr(SLV_WAKE, WAKE_MASK), 32'h0000_00FF);
    run_one_shot(0, 5);
    idle_cycles(2);
    assert (pcm_irq === 1'b0) else report_mismatch("Masked timer caused a wake");
    ahb_write(reg_addr(SLV_TIMER, tmr_reg(0, TMR_STAT)), 32'h1);

    // Hibernate, mask open but only GPIO may wake
    ahb_write(reg_addr(SLV_WAKE, WAKE_MASK), 32'h0);
    ahb_write(reg_addr(SLV_WAKE, WAKE_ISO), 32'h1);
    assert (isolate_mem === 1'b1) else report_mismatch("Isolate not set");
    run_one_shot(0, 5);
    idle_cycles(2);
    assert (pcm_irq === 1'b0 && isolate_mem === 1'b1)
      else report_mismatch("Timer woke from hibernate");
    gpio_in[pin] = 1'b1;   // IEN still set from step 3
    wait_gpio_irq(8);
    idle_cycles(2);
    assert (pcm_irq === 1'b1) else report_mismatch("GPIO irq caused no wake");
    assert (isolate_mem === 1'b0) else report_mismatch("Isolate not cleared by wake");
    read_check(reg_addr(SLV_WAKE, WAKE_ISO), 32'd0, "WAKE_ISO");

    $display("All checks passed");
    $finish;
  end

endmodule

/* project.f */
+incdir+dv
source/apb_sub_pkg.sv
source/ahb_apb_bridge.sv
source/apb_gpio.sv
source/apb_timer.sv
source/apb_wake_ctrl.sv
source/apb_subsystem.sv
dv/tb_apb_subsystem.sv

/* Makefile */
# Verilator flow for the APB subsystem, run from the project root
TOP := tb_apb_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f project.f

# Nonzero exit from the binary marks a failing run
sim:
	verilator --binary --assert --top-module $(TOP) -f project.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
